// ==== all.f ====
design/gf_pkg.sv
design/gf_issue_if.sv
design/gf_reg_if.sv
design/gf_sequencer.sv
design/gf_alu.sv
design/gf_regfile.sv
design/gf_coproc_top.sv
tb/gf_coproc_assert.sv
tb/gf_coproc_checker.sv
tb/gf_coproc_tb.sv

// ==== Makefile ====
TOP := gf_coproc_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== tb/gf_coproc_tb.sv ====
/* Runs six programs from a table and checks registers against a GF(2^8) model.
   r8..r11 hold fixed constants; every run also tries a host write while busy */
`timescale 1ns/1ps
`default_nettype none

module gf_coproc_tb import gf_pkg::*; ();

    localparam int NUM_TESTS    = 6;
    localparam int MAX_INSTR    = 8;
    localparam int NUM_REGS     = 2**REG_AW;
    localparam int DONE_TIMEOUT = 2000;

    logic               clk;
    logic               reset;
    logic               start;
    logic               prog_we;
    logic [PROG_AW-1:0] prog_addr;
    logic [INSTR_W-1:0] prog_data;
    logic               reg_we;
    logic [REG_AW-1:0]  reg_addr;
    logic [ELEM_W-1:0]  reg_wdata;
    logic [ELEM_W-1:0]  reg_rdata;
    logic               busy;
    logic               done;
    logic               chk_valid;
    logic [ELEM_W-1:0]  chk_exp;
    int                 chk_errors;

    // Test table
    string                 test_name  [NUM_TESTS];
    gf_instr_t             test_prog  [NUM_TESTS][MAX_INSTR];
    int                    test_len   [NUM_TESTS];
    logic [NUM_REGS-1:0]   check_mask [NUM_TESTS];

    logic [ELEM_W-1:0]     model_regs [NUM_REGS];
    logic [31:0]           lfsr_state;
    logic                  timed_out;

    gf_coproc_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .reg_we    (reg_we),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .busy      (busy),
        .done      (done)
    );

    gf_coproc_checker u_chk (
        .clk         (clk),
        .reset       (reset),
        .reg_rdata   (reg_rdata),
        .reg_addr    (reg_addr),
        .busy        (busy),
        .start       (start),
        .done        (done),
        .chk_valid   (chk_valid),
        .chk_exp     (chk_exp),
        .error_total (chk_errors)
    );

    bind gf_sequencer gf_coproc_assert u_assert (
        .clk           (clk),
        .reset         (reset),
        .credits       (credits),
        .issue_valid   (issue.issue_valid),
        .credit_return (issue.credit_return),
        .done          (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [ELEM_W-1:0] rand_elem();
        logic [ELEM_W-1:0] v;
        v = '0;
        for (int i = 0; i < ELEM_W; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[ELEM_W-2:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Shift and add, multiplier LSB first
    function automatic logic [ELEM_W-1:0] field_mul(input logic [ELEM_W-1:0] a,
                                                    input logic [ELEM_W-1:0] b);
        logic [ELEM_W-1:0] x;
        logic [ELEM_W-1:0] y;
        logic [ELEM_W-1:0] acc;
        x = a;
        y = b;
        acc = '0;
        for (int i = 0; i < ELEM_W; i++)
        begin
            if (y[0])
            begin
                acc = acc ^ x;
            end
            x = x[ELEM_W-1] ? ({x[ELEM_W-2:0], 1'b0} ^ GF_POLY) : {x[ELEM_W-2:0], 1'b0};
            y = y >> 1;
        end
        return acc;
    endfunction

    // a^(3^times), times 0 counts as one
    function automatic logic [ELEM_W-1:0] field_cube_pow(input logic [ELEM_W-1:0] a,
                                                         input int times);
        logic [ELEM_W-1:0] v;
        int n;
        v = a;
        n = (times == 0) ? 1 : times;
        repeat (n)
        begin
            v = field_mul(field_mul(v, v), v);
        end
        return v;
    endfunction

    function automatic gf_instr_t arith_instr(input gf_op_e op, input int dest,
                                              input int src1, input int src2, input int times);
        gf_instr_t w;
        w = '0;
        w.arith.op    = op;
        w.arith.dest  = REG_AW'(dest);
        w.arith.src1  = REG_AW'(src1);
        w.arith.src2  = REG_AW'(src2);
        w.arith.times = CNT_W'(times);
        return w;
    endfunction

    function automatic gf_instr_t ctrl_instr(input gf_op_e op, input int count,
                                             input int target);
        gf_instr_t w;
        w = '0;
        w.ctrl.op     = op;
        w.ctrl.count  = CNT_W'(count);
        w.ctrl.target = PROG_AW'(target);
        return w;
    endfunction

    function automatic logic [NUM_REGS-1:0] mask_range(input int lo, input int hi);
        logic [NUM_REGS-1:0] m;
        m = '0;
        for (int i = lo; i <= hi; i++)
        begin
            m[i] = 1'b1;
        end
        return m;
    endfunction

    task automatic add_instr(input int t, input gf_instr_t w);
        test_prog[t][test_len[t]] = w;
        test_len[t]++;
    endtask

    task automatic build_table();
        for (int t = 0; t < NUM_TESTS; t++)
        begin
            test_len[t] = 0;
        end
        test_name[0] = "add";
        add_instr(0, arith_instr(OP_ADD, 16, 0, 1, 0));
        add_instr(0, arith_instr(OP_ADD, 17, 2, 3, 0));
        add_instr(0, arith_instr(OP_ADD, 18, 4, 4, 0));
        add_instr(0, ctrl_instr(OP_HALT, 0, 0));
        check_mask[0] = mask_range(16, 18);
        // r8 = 0, r9 = 1, r10 = 8'h80
        test_name[1] = "mul";
        add_instr(1, arith_instr(OP_MUL, 16, 0, 1, 0));
        add_instr(1, arith_instr(OP_MUL, 17, 0, 8, 0));
        add_instr(1, arith_instr(OP_MUL, 18, 1, 9, 0));
        add_instr(1, arith_instr(OP_MUL, 19, 10, 10, 0));
        add_instr(1, arith_instr(OP_MUL, 20, 2, 10, 0));
        add_instr(1, ctrl_instr(OP_HALT, 0, 0));
        check_mask[1] = mask_range(16, 20);
        test_name[2] = "cube";
        add_instr(2, arith_instr(OP_CUBE, 16, 0, 0, 1));
        add_instr(2, arith_instr(OP_CUBE, 17, 1, 0, 2));
        add_instr(2, arith_instr(OP_CUBE, 18, 2, 0, 5));
        add_instr(2, ctrl_instr(OP_HALT, 0, 0));
        check_mask[2] = mask_range(16, 18);
        // Second loop only runs its full count if the counter re-armed
        test_name[3] = "loop";
        add_instr(3, arith_instr(OP_ADD, 20, 0, 8, 0));
        add_instr(3, arith_instr(OP_MUL, 20, 20, 11, 0));
        add_instr(3, ctrl_instr(OP_LOOP, 4, 1));
        add_instr(3, arith_instr(OP_ADD, 21, 1, 8, 0));
        add_instr(3, arith_instr(OP_MUL, 21, 21, 10, 0));
        add_instr(3, ctrl_instr(OP_LOOP, 2, 4));
        add_instr(3, ctrl_instr(OP_HALT, 0, 0));
        check_mask[3] = mask_range(20, 21);
        // Long CUBE at the head fills the queue behind it
        test_name[4] = "backpressure";
        add_instr(4, arith_instr(OP_CUBE, 22, 0, 0, 3));
        add_instr(4, arith_instr(OP_MUL, 23, 22, 1, 0));
        add_instr(4, arith_instr(OP_ADD, 24, 23, 2, 0));
        add_instr(4, arith_instr(OP_MUL, 25, 24, 24, 0));
        add_instr(4, arith_instr(OP_CUBE, 26, 25, 0, 1));
        add_instr(4, arith_instr(OP_ADD, 27, 26, 22, 0));
        add_instr(4, ctrl_instr(OP_HALT, 0, 0));
        check_mask[4] = mask_range(22, 27);
        test_name[5] = "halt_only";
        add_instr(5, ctrl_instr(OP_HALT, 0, 0));
        check_mask[5] = '1;
    endtask

    // Sequential evaluation of a program, loop body runs count+1 times
    task automatic model_run(input int t);
        gf_instr_t w;
        int pc;
        int steps;
        int remaining;
        logic in_loop;
        pc = 0;
        steps = 0;
        remaining = 0;
        in_loop = 1'b0;
        while (pc < test_len[t] && steps < 1000)
        begin
            w = test_prog[t][pc];
            steps++;
            pc++;
            case (w.arith.op)
                OP_ADD:
                    model_regs[w.arith.dest] = model_regs[w.arith.src1] ^
                                               model_regs[w.arith.src2];
                OP_MUL:
                    model_regs[w.arith.dest] = field_mul(model_regs[w.arith.src1],
                                                         model_regs[w.arith.src2]);
                OP_CUBE:
                    model_regs[w.arith.dest] = field_cube_pow(model_regs[w.arith.src1],
                                                              w.arith.times);
                OP_LOOP:
                begin
                    if (!in_loop)
                    begin
                        remaining = w.ctrl.count;
                    end
                    if (remaining != 0)
                    begin
                        remaining--;
                        in_loop = 1'b1;
                        pc = w.ctrl.target;
                    end
                    else
                    begin
                        in_loop = 1'b0;
                    end
                end
                default:
                    pc = test_len[t];
            endcase
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #5;
    endtask

    task automatic host_write(input int a, input logic [ELEM_W-1:0] v);
        reg_we    = 1'b1;
        reg_addr  = REG_AW'(a);
        reg_wdata = v;
        model_regs[a] = v;
        tick();
        reg_we = 1'b0;
    endtask

    task automatic prog_write(input int a, input gf_instr_t w);
        prog_we   = 1'b1;
        prog_addr = PROG_AW'(a);
        prog_data = w;
        tick();
        prog_we = 1'b0;
    endtask

    task automatic run_test(input int t);
        int cycles;
        for (int i = 0; i < 8; i++)
        begin
            host_write(i, rand_elem());
        end
        for (int i = 0; i < test_len[t]; i++)
        begin
            prog_write(i, test_prog[t][i]);
        end
        model_run(t);
        start = 1'b1;
        tick();
        start = 1'b0;
        // Busy is high at the next edge, so this write must be dropped
        reg_we    = 1'b1;
        reg_addr  = REG_AW'(12);
        reg_wdata = ~model_regs[12];
        tick();
        reg_we = 1'b0;
        cycles = 0;
        while (!done && cycles < DONE_TIMEOUT)
        begin
            tick();
            cycles++;
        end
        if (!done)
        begin
            $display("ERROR: test %s did not raise done within %0d cycles",
                     test_name[t], DONE_TIMEOUT);
            timed_out = 1'b1;
        end
        else
        begin
            for (int a = 0; a < NUM_REGS; a++)
            begin
                if (check_mask[t][a])
                begin
                    reg_addr  = REG_AW'(a);
                    chk_valid = 1'b1;
                    chk_exp   = model_regs[a];
                    tick();
                end
            end
            chk_valid = 1'b0;
            tick();
            u_chk.end_test(test_name[t]);
        end
    endtask

    initial
    begin
        reset      = 1'b1;
        start      = 1'b0;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        reg_we     = 1'b0;
        reg_addr   = '0;
        reg_wdata  = '0;
        chk_valid  = 1'b0;
        chk_exp    = '0;
        lfsr_state = 32'h8e13;
        timed_out  = 1'b0;
        for (int i = 0; i < NUM_REGS; i++)
        begin
            model_regs[i] = '0;
        end
        build_table();
        repeat (16) tick();
        reset = 1'b0;
        tick();
        host_write(8, 8'h00);
        host_write(9, 8'h01);
        host_write(10, 8'h80);
        host_write(11, 8'h03);
        for (int t = 0; t < NUM_TESTS && !timed_out; t++)
        begin
            run_test(t);
        end
        u_chk.report();
        if (!timed_out && chk_errors == 0 && u_dut.u_seq.u_assert.fail_count == 0)
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/gf_coproc_checker.sv ====
/* Compares host readback one cycle after each address is applied, and busy against start
   and done. Also counts done pulses so each run can be checked for exactly one */
`timescale 1ns/1ps
`default_nettype none

module gf_coproc_checker import gf_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [ELEM_W-1:0] reg_rdata,
    input  logic [REG_AW-1:0] reg_addr,
    input  logic              busy,
    input  logic              start,
    input  logic              done,
    input  logic              chk_valid,
    input  logic [ELEM_W-1:0] chk_exp,
    output int                error_total
);

    logic              valid_q;
    logic [ELEM_W-1:0] exp_q;
    logic [REG_AW-1:0] addr_q;
    logic              done_q;
    logic              start_q;
    int                done_rises = 0;
    int                read_errors = 0;
    int                run_errors = 0;
    int                checks = 0;
    int                done_mark = 0;
    int                err_mark = 0;
    int                check_mark = 0;
    int                tests_ok = 0;
    int                tests_bad = 0;

    assign error_total = read_errors + run_errors;

    always @(posedge clk)
    begin
        if (reset)
        begin
            valid_q <= 1'b0;
            done_q  <= 1'b0;
            start_q <= 1'b0;
        end
        else
        begin
            valid_q <= chk_valid;
            exp_q   <= chk_exp;
            addr_q  <= reg_addr;
            done_q  <= done;
            start_q <= start;
            if (done && !done_q)
            begin
                done_rises <= done_rises + 1;
            end
        end
    end

    // reg_rdata settles after the edge, so compare at the falling edge
    always @(negedge clk)
    begin
        if (valid_q)
        begin
            checks++;
            if (reg_rdata !== exp_q)
            begin
                read_errors++;
                $display("MISMATCH at %0d ns: reg_rdata (r%0d) expected %02h, actual %02h",
                         $time, addr_q, exp_q, reg_rdata);
            end
        end
        if (!reset)
        begin
            // A start while idle sets busy on the same edge
            if (start_q && (busy !== 1'b1))
            begin
                run_errors++;
                $display("MISMATCH at %0d ns: busy after start expected 1, actual %b",
                         $time, busy);
            end
            // Busy falls on the edge that raises done
            if ((done === 1'b1) && (busy !== 1'b0))
            begin
                run_errors++;
                $display("MISMATCH at %0d ns: busy while done expected 0, actual %b",
                         $time, busy);
            end
        end
    end

    task automatic end_test(input string name);
        int runs;
        int errs;
        runs = done_rises - done_mark;
        if (runs != 1)
        begin
            run_errors++;
            $display("ERROR: done rose %0d times during test %s, expected once", runs, name);
        end
        errs = read_errors + run_errors - err_mark;
        if (errs == 0)
        begin
            tests_ok++;
            $display("test %s: ok, %0d registers checked", name, checks - check_mark);
        end
        else
        begin
            tests_bad++;
            $display("test %s: FAILED with %0d errors", name, errs);
        end
        done_mark  = done_rises;
        err_mark   = read_errors + run_errors;
        check_mark = checks;
    endtask

    task automatic report();
        $display("tests ok %0d, tests failed %0d, registers checked %0d, errors %0d",
                 tests_ok, tests_bad, checks, read_errors + run_errors);
    endtask

endmodule

`default_nettype wire

// ==== tb/gf_coproc_assert.sv ====
/* Credit and issue rules on the sequencer side of the issue channel.
   Bound into gf_sequencer; fail_count is read by the testbench top */
`timescale 1ns/1ps
`default_nettype none

module gf_coproc_assert import gf_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic [CREDIT_W-1:0] credits,
    input  logic                issue_valid,
    input  logic                credit_return,
    input  logic                done
);

    localparam int OUT_W = CREDIT_W + 1;

    int               fail_count = 0;
    logic [OUT_W-1:0] outstanding;

    // Commands in flight, tallied from the channel signals alone
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            outstanding <= '0;
        end
        else
        begin
            outstanding <= outstanding + OUT_W'(issue_valid) - OUT_W'(credit_return);
        end
    end

    // An underflow from zero wraps above the limit as well
    credit_limit: assert property (@(posedge clk) disable iff (reset)
        credits <= CREDIT_W'(CREDITS))
    else
    begin
        $error("credit count %0d outside 0..%0d", credits, CREDITS);
        fail_count++;
    end

    no_issue_without_credit: assert property (@(posedge clk) disable iff (reset)
        issue_valid |-> (outstanding < OUT_W'(CREDITS)))
    else
    begin
        $error("issue_valid high with all %0d credits in use", CREDITS);
        fail_count++;
    end

    // A write-back needs an outstanding command
    return_needs_outstanding: assert property (@(posedge clk) disable iff (reset)
        credit_return |-> (credits != CREDIT_W'(CREDITS)))
    else
    begin
        $error("credit returned with no command outstanding");
        fail_count++;
    end

    done_all_retired: assert property (@(posedge clk) disable iff (reset)
        done |-> (credits == CREDIT_W'(CREDITS)))
    else
    begin
        $error("done high with credits still outstanding");
        fail_count++;
    end

endmodule

`default_nettype wire

// ==== design/gf_coproc_top.sv ====
/* GF(2^8) coprocessor. Load program and registers while idle, pulse start,
   wait for done, then read back; host access during a run is ignored */
`timescale 1ns/1ps
`default_nettype none

module gf_coproc_top import gf_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  logic               prog_we,
    input  logic [PROG_AW-1:0] prog_addr,
    input  logic [INSTR_W-1:0] prog_data,
    input  logic               reg_we,
    input  logic [REG_AW-1:0]  reg_addr,
    input  logic [ELEM_W-1:0]  reg_wdata,
    output logic [ELEM_W-1:0]  reg_rdata,
    output logic               busy,
    output logic               done
);

    gf_issue_if issue_bus ();
    gf_reg_if   reg_bus ();

    gf_sequencer u_seq (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .issue     (issue_bus.seq),
        .busy      (busy),
        .done      (done)
    );

    gf_alu u_alu (
        .clk   (clk),
        .reset (reset),
        .issue (issue_bus.alu),
        .regs  (reg_bus.alu)
    );

    gf_regfile u_rf (
        .clk       (clk),
        .reset     (reset),
        .regs      (reg_bus.rf),
        .busy      (busy),
        .reg_we    (reg_we),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata)
    );

endmodule

`default_nettype wire

// ==== design/gf_regfile.sv ====
/* 64 field registers, cleared at reset. Host writes are dropped while busy;
   the host read port is registered and works at any time */
`timescale 1ns/1ps
`default_nettype none

module gf_regfile import gf_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    gf_reg_if.rf              regs,
    input  logic              busy,
    input  logic              reg_we,
    input  logic [REG_AW-1:0] reg_addr,
    input  logic [ELEM_W-1:0] reg_wdata,
    output logic [ELEM_W-1:0] reg_rdata
);

    logic [ELEM_W-1:0] mem [2**REG_AW];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 2**REG_AW; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (regs.we)
        begin
            mem[regs.waddr] <= regs.wdata;
        end
        else if (reg_we && !busy)
        begin
            mem[reg_addr] <= reg_wdata;
        end
    end

    // ALU operand ports
    assign regs.rdata_a = mem[regs.raddr_a];
    assign regs.rdata_b = mem[regs.raddr_b];

    // Host sees the old value if a write lands on the same edge
    always_ff @(posedge clk)
    begin
        reg_rdata <= mem[reg_addr];
    end

endmodule

`default_nettype wire

// ==== design/gf_alu.sv ====
/* In-order execution unit. MUL is bit-serial, 8 cycles; CUBE runs 16 cycles per repetition,
   times 0 counts as one. Queue depth equals the credit count, so it cannot overflow */
`timescale 1ns/1ps
`default_nettype none

module gf_alu import gf_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    gf_issue_if.alu issue,
    gf_reg_if.alu   regs
);

    gf_cmd_t                     q_mem [CREDITS];
    logic [QPTR_W-1:0]           wr_ptr;
    logic [QPTR_W-1:0]           rd_ptr;
    logic [CREDIT_W-1:0]         q_count;
    gf_cmd_t                     head;
    logic                        start_cmd;

    logic                        running;
    gf_op_e                      op_r;
    logic [REG_AW-1:0]           dest_r;
    logic [CNT_W-1:0]            reps_left;
    logic                        second;
    logic [$clog2(ELEM_W)-1:0]   bit_cnt;
    logic                        last_step;
    logic [ELEM_W-1:0]           base;
    logic [ELEM_W-1:0]           mx;
    logic [ELEM_W-1:0]           my;
    logic [ELEM_W-1:0]           p;
    logic [ELEM_W-1:0]           mul_next;
    logic                        finish;

    // Command queue
    always_ff @(posedge clk)
    begin
        if (issue.issue_valid)
        begin
            q_mem[wr_ptr] <= issue.cmd;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end
        else
        begin
            if (issue.issue_valid)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (start_cmd)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            q_count <= q_count + CREDIT_W'(issue.issue_valid) - CREDIT_W'(start_cmd);
        end
    end

    assign head      = q_mem[rd_ptr];
    assign start_cmd = !running && (q_count != '0);

    // Operands of the head are read when it starts
    assign regs.raddr_a = head.src1;
    assign regs.raddr_b = head.src2;

    // One Horner step, MSB of the multiplier first: p = p*x + bit*mx
    assign mul_next = {p[ELEM_W-2:0], 1'b0} ^ (p[ELEM_W-1] ? GF_POLY : '0) ^
                      (my[ELEM_W-1] ? mx : '0);

    assign last_step = &bit_cnt;

    always_comb
    begin
        finish = 1'b0;
        if (running)
        begin
            if (op_r == OP_ADD)
            begin
                finish = 1'b1;
            end
            else if (last_step)
            begin
                finish = (op_r == OP_MUL) || (second && (reps_left == '0));
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            running <= 1'b0;
        end
        else if (start_cmd)
        begin
            running <= 1'b1;
        end
        else if (finish)
        begin
            running <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (start_cmd)
        begin
            op_r      <= head.op;
            dest_r    <= head.dest;
            reps_left <= (head.times == '0) ? '0 : head.times - 1'b1;
            second    <= 1'b0;
            bit_cnt   <= '0;
            base      <= regs.rdata_a;
            mx        <= regs.rdata_a;
            my        <= (head.op == OP_CUBE) ? regs.rdata_a : regs.rdata_b;
            // ADD keeps its sum in p
            p         <= (head.op == OP_ADD) ? (regs.rdata_a ^ regs.rdata_b) : '0;
        end
        else if (running && (op_r != OP_ADD) && !finish)
        begin
            if (!last_step)
            begin
                p       <= mul_next;
                my      <= {my[ELEM_W-2:0], 1'b0};
                bit_cnt <= bit_cnt + 1'b1;
            end
            else if (!second)
            begin
                // Square done, multiply it by the value being cubed
                second  <= 1'b1;
                mx      <= mul_next;
                my      <= base;
                p       <= '0;
                bit_cnt <= '0;
            end
            else
            begin
                // Next repetition cubes the previous cube
                second    <= 1'b0;
                reps_left <= reps_left - 1'b1;
                base      <= mul_next;
                mx        <= mul_next;
                my        <= mul_next;
                p         <= '0;
                bit_cnt   <= '0;
            end
        end
    end

    assign regs.we             = finish;
    assign regs.waddr          = dest_r;
    assign regs.wdata          = (op_r == OP_ADD) ? p : mul_next;
    assign issue.credit_return = finish;

endmodule

`default_nettype wire

// ==== design/gf_sequencer.sv ====
/* Fetch, decode and a single level of counted loop. Program writes only land while idle.
   Unknown opcodes stop fetch like HALT */
`timescale 1ns/1ps
`default_nettype none

module gf_sequencer import gf_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  logic               prog_we,
    input  logic [PROG_AW-1:0] prog_addr,
    input  gf_instr_t          prog_data,
    gf_issue_if.seq            issue,
    output logic               busy,
    output logic               done
);

    gf_instr_t             prog_mem [2**PROG_AW];
    gf_instr_t             instr;
    logic [PROG_AW-1:0]    pc;
    logic                  halted;
    logic                  run;
    logic                  is_arith;
    logic                  loop_active;
    logic [CNT_W-1:0]      loop_cnt;
    logic [CNT_W-1:0]      loop_eff;
    logic [CREDIT_W-1:0]   credits;
    logic                  credits_full;

    always_ff @(posedge clk)
    begin
        if (prog_we && !busy)
        begin
            prog_mem[prog_addr] <= prog_data;
        end
    end

    // Instruction at pc is decoded in the same cycle
    assign instr = prog_mem[pc];
    assign run   = busy && !halted;

    assign is_arith = (instr.arith.op == OP_ADD) || (instr.arith.op == OP_MUL) ||
                      (instr.arith.op == OP_CUBE);

    // First visit of a LOOP takes the count from the word, later visits the counter
    assign loop_eff = loop_active ? loop_cnt : instr.ctrl.count;

    assign credits_full = (credits == CREDIT_W'(CREDITS));

    assign issue.issue_valid = run && is_arith && (credits != '0);
    assign issue.cmd         = '{op:    instr.arith.op,
                                 dest:  instr.arith.dest,
                                 src1:  instr.arith.src1,
                                 src2:  instr.arith.src2,
                                 times: instr.arith.times};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            credits <= CREDIT_W'(CREDITS);
        end
        else
        begin
            case ({issue.issue_valid, issue.credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy        <= 1'b0;
            done        <= 1'b0;
            halted      <= 1'b0;
            pc          <= '0;
            loop_active <= 1'b0;
        end
        else if (!busy)
        begin
            if (start)
            begin
                busy        <= 1'b1;
                done        <= 1'b0;
                halted      <= 1'b0;
                pc          <= '0;
                loop_active <= 1'b0;
            end
        end
        else if (halted)
        begin
            // Wait for every issued command to retire
            if (credits_full)
            begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
        else if (is_arith)
        begin
            // Stall here on zero credits
            if (credits != '0)
            begin
                pc <= pc + 1'b1;
            end
        end
        else if (instr.ctrl.op == OP_LOOP)
        begin
            if (loop_eff != '0)
            begin
                loop_cnt    <= loop_eff - 1'b1;
                loop_active <= 1'b1;
                pc          <= instr.ctrl.target;
            end
            else
            begin
                loop_active <= 1'b0;
                pc          <= pc + 1'b1;
            end
        end
        else
        begin
            halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/gf_reg_if.sv ====
/* ALU access to the register file. Read data is combinational from the addresses */
`timescale 1ns/1ps
`default_nettype none

interface gf_reg_if import gf_pkg::*; ();

    logic [REG_AW-1:0] raddr_a;
    logic [REG_AW-1:0] raddr_b;
    logic [ELEM_W-1:0] rdata_a;
    logic [ELEM_W-1:0] rdata_b;
    logic              we;
    logic [REG_AW-1:0] waddr;
    logic [ELEM_W-1:0] wdata;

    modport alu (
        output raddr_a, raddr_b, we, waddr, wdata,
        input  rdata_a, rdata_b
    );

    modport rf (
        input  raddr_a, raddr_b, we, waddr, wdata,
        output rdata_a, rdata_b
    );

endinterface

`default_nettype wire

// ==== design/gf_issue_if.sv ====
/* Sequencer to ALU command channel. No ready signal: the sequencer
   only issues while it holds a credit, one credit comes back per retired command */
`timescale 1ns/1ps
`default_nettype none

interface gf_issue_if import gf_pkg::*; ();

    logic    issue_valid;
    gf_cmd_t cmd;
    logic    credit_return;

    modport seq (
        output issue_valid,
        output cmd,
        input  credit_return
    );

    modport alu (
        input  issue_valid,
        input  cmd,
        output credit_return
    );

endinterface

`default_nettype wire

// ==== design/gf_pkg.sv ====
/* Shared constants and instruction formats for the GF(2^8) coprocessor.
   Only ADD, MUL and CUBE are issued to the ALU; LOOP and HALT stay in the sequencer */
`default_nettype none

package gf_pkg;

    localparam int ELEM_W   = 8;
    localparam int REG_AW   = 6;
    localparam int PROG_AW  = 6;
    localparam int CNT_W    = 6;
    localparam int INSTR_W  = 27;
    localparam int CREDITS  = 2;
    localparam int CREDIT_W = $clog2(CREDITS + 1);
    localparam int QPTR_W   = $clog2(CREDITS);

    // Low byte of x^8+x^4+x^3+x+1
    localparam logic [ELEM_W-1:0] GF_POLY = 8'h1B;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_MUL  = 3'd1,
        OP_CUBE = 3'd2,
        OP_LOOP = 3'd3,
        OP_HALT = 3'd4
    } gf_op_e;

    typedef struct packed {
        gf_op_e              op;
        logic [REG_AW-1:0]   dest;
        logic [REG_AW-1:0]   src1;
        logic [REG_AW-1:0]   src2;
        logic [CNT_W-1:0]    times;
    } gf_arith_t;

    typedef struct packed {
        gf_op_e              op;
        logic [CNT_W-1:0]    count;
        logic [PROG_AW-1:0]  target;
        logic [INSTR_W-3-CNT_W-PROG_AW-1:0] reserved;
    } gf_ctrl_t;

    // The op field overlays the same bits in both views
    typedef union packed {
        gf_arith_t arith;
        gf_ctrl_t  ctrl;
    } gf_instr_t;

    // Command as queued in the ALU
    typedef struct packed {
        gf_op_e              op;
        logic [REG_AW-1:0]   dest;
        logic [REG_AW-1:0]   src1;
        logic [REG_AW-1:0]   src2;
        logic [CNT_W-1:0]    times;
    } gf_cmd_t;

endpackage

`default_nettype wire
